// File: rtl/sbc_config.svh
// SBC bus glue configuration: port numbers, ROM window, wait-state loads and field widths
`ifndef SBC_CONFIG_SVH
`define SBC_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// I/O port numbers, compared against A7-A0 of an IN or OUT
//////////////////////////////////////////////////////////////////////

`define PORT_LEDBAR     8'h06   // LED bar, write and read back
`define PORT_MISC       8'h07   // misc control, rom bank and disable
`define PORT_PAGE       8'h36   // out: ram A16 page, in: iobyte switches
`define PORT_PANEL      8'hFF   // front panel leds

//////////////////////////////////////////////////////////////////////
// memory map
//////////////////////////////////////////////////////////////////////

`define ROM_NIBBLE      4'hF    // A15-A12 value of the 4k rom window

//////////////////////////////////////////////////////////////////////
// wait-state loads
//////////////////////////////////////////////////////////////////////

// shifted out msb first with ones behind, so each leading zero
// holds WAIT low for one more clock
`define ROM_WAIT_VALUE  8'h7F   // one wait
`define IO_WAIT_VALUE   8'h3F   // two waits

//////////////////////////////////////////////////////////////////////
// field widths
//////////////////////////////////////////////////////////////////////

`define STATUS_WIDTH    7       // s100 status vector
`define ROM_ADDR_WIDTH  14      // two bank bits plus A11-A0
`define RAM_ADDR_WIDTH  17      // page bit plus A15-A0

// bit positions in the status vector
`define ST_HLTA         0       // halt acknowledge
`define ST_OUT          1       // output cycle
`define ST_INP          2       // input cycle
`define ST_MEMR         3       // memory read
`define ST_NWO          4       // write out, active low
`define ST_M1           5       // opcode fetch
`define ST_INTA         6       // interrupt acknowledge

`endif

// File: rtl/sbcBusPkg.sv
// Bus types package: the CPU address word and its memory and I/O views
package sbcBusPkg;

    //////////////////////////////////////////////////////////////////////
    // cpu address word
    //////////////////////////////////////////////////////////////////////

    // on IN and OUT the Z80 puts the accumulator (or B) on A15-A8
    // and the port number on A7-A0, so the same 16 bits read as
    // either a memory address or a data/port pair
    typedef union packed {
        logic [15:0] mem;               // full memory address
        struct packed {
            logic [7:0] ioData;         // A15-A8, accumulator during io
            logic [7:0] port;           // A7-A0, port number
        } io;
    } cpuAddress_u;

endpackage

// File: rtl/busDecode.sv
// Bus cycle decoder: cycle type, chip and port selects, live status and boot NOP flag
`include "sbc_config.svh"

module busDecode (
    input  logic                        pll0_2MHz,
    input  logic                        n_reset,
    input  logic                        nMreq,
    input  logic                        nIorq,
    input  logic                        nRd,
    input  logic                        nWr,
    input  logic                        nM1,
    input  logic                        nRfsh,
    input  logic                        nHalt,
    input  sbcBusPkg::cpuAddress_u      cpuAddress,
    input  logic                        romDisable,    // misc port bit 1
    output logic                        memRd,
    output logic                        memWr,
    output logic                        ioRd,
    output logic                        ioWr,
    output logic                        romSel,
    output logic                        ramSel,
    output logic                        ledBarSel,
    output logic                        miscSel,
    output logic                        pageSel,
    output logic                        panelSel,
    output logic                        bootNop,
    output logic                        cycleStart,
    output logic [`STATUS_WIDTH-1:0]    status
);

    logic memCycle;     // mreq outside refresh
    logic ioCycle;      // iorq outside interrupt ack
    logic request;      // any bus request active
    logic reqPrev;      // request level last clock
    logic inta;         // M1 together with IORQ

    //////////////////////////////////////////////////////////////////////
    // cycle type
    //////////////////////////////////////////////////////////////////////

    assign memCycle = !nMreq && nRfsh;          // refresh cycles never hit memory
    assign inta     = !nM1 && !nIorq;           // int ack, no port access
    assign ioCycle  = !nIorq && nM1;

    assign memRd = memCycle && !nRd;
    assign memWr = memCycle && !nWr;
    assign ioRd  = ioCycle && !nRd;
    assign ioWr  = ioCycle && !nWr;

    assign request    = memCycle || !nIorq;
    assign cycleStart = request && !reqPrev;    // first clock of a request

    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            reqPrev <= 1'b0;
        end else begin
            reqPrev <= request;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // memory and port selects
    //////////////////////////////////////////////////////////////////////

    // rom window at F000-FFFF unless switched off from the misc port
    assign romSel = (cpuAddress.mem[15:12] == `ROM_NIBBLE) && !romDisable;
    assign ramSel = !romSel;                    // ram fills the rest of the map

    assign ledBarSel = (cpuAddress.io.port == `PORT_LEDBAR);
    assign miscSel   = (cpuAddress.io.port == `PORT_MISC);
    assign pageSel   = (cpuAddress.io.port == `PORT_PAGE);
    assign panelSel  = (cpuAddress.io.port == `PORT_PANEL);

    //////////////////////////////////////////////////////////////////////
    // boot nop feed
    //////////////////////////////////////////////////////////////////////

    // while set, memory reads outside the rom return 00 so the pc
    // runs up through memory until it reaches the rom window
    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            bootNop <= 1'b1;
        end else if (memCycle && romSel) begin
            bootNop <= 1'b0;                    // first rom access ends it
        end
    end

    //////////////////////////////////////////////////////////////////////
    // live status, latched by busResult at cycle start
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        status            = '0;
        status[`ST_HLTA]  = !nHalt;
        status[`ST_OUT]   = ioWr;
        status[`ST_INP]   = ioRd;
        status[`ST_MEMR]  = memRd;
        status[`ST_NWO]   = !(memWr || ioWr);   // low on any write
        status[`ST_M1]    = !nM1;
        status[`ST_INTA]  = inta;
    end

endmodule

// File: rtl/portExecute.sv
// Output port registers and ROM/I/O wait-state shift register
`include "sbc_config.svh"

module portExecute (
    input  logic        pll0_2MHz,
    input  logic        n_reset,
    input  logic [7:0]  cpuDataOut,
    input  logic        ioWr,
    input  logic        ledBarSel,
    input  logic        miscSel,
    input  logic        pageSel,
    input  logic        panelSel,
    input  logic        cycleStart,
    input  logic        romSel,
    input  logic        memRd,
    input  logic        ioRd,
    output logic [7:0]  barLeds,
    output logic [7:0]  frontPanel,
    output logic        romDisable,
    output logic [1:0]  romBank,
    output logic        ramPage,
    output logic        nWait
);

    logic [2:0] miscReg;        // only D2-D0 of port 07 are used
    logic       pageReg;        // D0 of port 36
    logic [7:0] waitShift;      // msb drives WAIT
    logic       romWaitLoad;
    logic       ioWaitLoad;

    //////////////////////////////////////////////////////////////////////
    // output ports
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            barLeds    <= 8'h00;
            frontPanel <= 8'h00;
            miscReg    <= 3'b000;
            pageReg    <= 1'b0;
        end else begin
            if (ioWr && ledBarSel) barLeds <= cpuDataOut;       // port 06
            if (ioWr && panelSel) frontPanel <= cpuDataOut;     // port FF
            if (ioWr && miscSel) miscReg <= cpuDataOut[2:0];    // port 07
            if (ioWr && pageSel) pageReg <= cpuDataOut[0];      // port 36
        end
    end

    assign romDisable = miscReg[1];
    assign romBank    = {miscReg[2], miscReg[0]};   // rom A13, A12
    assign ramPage    = pageReg;

    //////////////////////////////////////////////////////////////////////
    // wait-state generator
    //////////////////////////////////////////////////////////////////////

    // works like a 74LS165 with serial in tied high: loaded once per
    // cycle, then every clock moves a one in behind the zeros
    assign romWaitLoad = cycleStart && memRd && romSel;
    assign ioWaitLoad  = cycleStart && (ioRd || ioWr);

    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            waitShift <= 8'hFF;                         // no wait pending
        end else if (romWaitLoad) begin
            waitShift <= `ROM_WAIT_VALUE;
        end else if (ioWaitLoad) begin
            waitShift <= `IO_WAIT_VALUE;
        end else begin
            waitShift <= {waitShift[6:0], 1'b1};        // shift ones in
        end
    end

    assign nWait = waitShift[7];

endmodule

// File: rtl/busResult.sv
// CPU data-in mux, RAM/ROM addressing and strobes, S-100 status and address latch
`include "sbc_config.svh"

module busResult (
    input  logic                            pll0_2MHz,
    input  logic                            n_reset,
    input  sbcBusPkg::cpuAddress_u          cpuAddress,
    input  logic                            memRd,
    input  logic                            memWr,
    input  logic                            ioRd,
    input  logic                            romSel,
    input  logic                            ramSel,
    input  logic                            ledBarSel,
    input  logic                            pageSel,
    input  logic                            bootNop,
    input  logic                            cycleStart,
    input  logic [`STATUS_WIDTH-1:0]        status,
    input  logic [1:0]                      romBank,
    input  logic                            ramPage,
    input  logic [7:0]                      barLeds,
    input  logic [7:0]                      ioByte,
    input  logic [7:0]                      romData,
    input  logic [7:0]                      ramDataIn,
    input  logic [7:0]                      s100DataIn,
    output logic [7:0]                      cpuDataIn,
    output logic [`ROM_ADDR_WIDTH-1:0]      romAddress,
    output logic [`RAM_ADDR_WIDTH-1:0]      ramAddress,
    output logic                            ramNcs,
    output logic                            ramNoe,
    output logic                            ramNwr,
    output sbcBusPkg::cpuAddress_u          s100Address,
    output logic [`STATUS_WIDTH-1:0]        s100Status
);

    logic ioCycleLive;      // IN or OUT in progress

    //////////////////////////////////////////////////////////////////////
    // cpu data in
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (memRd && bootNop && !romSel) begin
            cpuDataIn = 8'h00;                  // nop until the rom is reached
        end else if (memRd && romSel) begin
            cpuDataIn = romData;
        end else if (memRd && ramSel) begin
            cpuDataIn = ramDataIn;
        end else if (ioRd && ledBarSel) begin
            cpuDataIn = barLeds;                // port 06 read back
        end else if (ioRd && pageSel) begin
            cpuDataIn = ioByte;                 // port 36 reads the switches
        end else begin
            cpuDataIn = s100DataIn;             // everything else from the bus
        end
    end

    //////////////////////////////////////////////////////////////////////
    // memory addressing and ram strobes
    //////////////////////////////////////////////////////////////////////

    assign romAddress = {romBank, cpuAddress.mem[11:0]};
    // page bit only moves the lower 32k, the top half stays common
    assign ramAddress = {ramPage && !cpuAddress.mem[15], cpuAddress.mem};

    assign ramNcs = !(ramSel && (memRd || memWr));
    assign ramNoe = !memRd;
    assign ramNwr = !(memWr && ramSel);

    //////////////////////////////////////////////////////////////////////
    // s100 status and address latch
    //////////////////////////////////////////////////////////////////////

    assign ioCycleLive = status[`ST_OUT] || status[`ST_INP];

    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            s100Status      <= '0;
            s100Address.mem <= 16'h0000;
        end else if (cycleStart) begin
            s100Status <= status;
            if (ioCycleLive) begin
                s100Address.mem <= {8'h00, cpuAddress.io.port};  // hide accumulator
            end else begin
                s100Address.mem <= cpuAddress.mem;
            end
        end
    end

endmodule

// File: rtl/sbcBusTop.sv
// Z80 SBC bus glue top level: decode, port execution and bus result stages
`include "sbc_config.svh"

module sbcBusTop (
    input  logic                            pll0_2MHz,
    input  logic                            n_reset,
    input  logic                            nMreq,
    input  logic                            nIorq,
    input  logic                            nRd,
    input  logic                            nWr,
    input  logic                            nM1,
    input  logic                            nRfsh,
    input  logic                            nHalt,
    input  sbcBusPkg::cpuAddress_u          cpuAddress,
    input  logic [7:0]                      cpuDataOut,
    input  logic [7:0]                      romData,
    input  logic [7:0]                      ramDataIn,
    input  logic [7:0]                      s100DataIn,
    input  logic [7:0]                      ioByte,
    output logic [7:0]                      cpuDataIn,
    output logic                            nWait,
    output logic [`ROM_ADDR_WIDTH-1:0]      romAddress,
    output logic [`RAM_ADDR_WIDTH-1:0]      ramAddress,
    output logic                            ramNcs,
    output logic                            ramNoe,
    output logic                            ramNwr,
    output sbcBusPkg::cpuAddress_u          s100Address,
    output logic [`STATUS_WIDTH-1:0]        s100Status,
    output logic [7:0]                      barLeds,
    output logic [7:0]                      frontPanel
);

    logic                       memRd;
    logic                       memWr;
    logic                       ioRd;
    logic                       ioWr;
    logic                       romSel;
    logic                       ramSel;
    logic                       ledBarSel;
    logic                       miscSel;
    logic                       pageSel;
    logic                       panelSel;
    logic                       bootNop;
    logic                       cycleStart;
    logic [`STATUS_WIDTH-1:0]   status;     // live, before the latch
    logic                       romDisable;
    logic [1:0]                 romBank;
    logic                       ramPage;

    //////////////////////////////////////////////////////////////////////
    // stages
    //////////////////////////////////////////////////////////////////////

    busDecode decode (
        .pll0_2MHz (pll0_2MHz), .n_reset (n_reset),
        .nMreq (nMreq), .nIorq (nIorq), .nRd (nRd), .nWr (nWr),
        .nM1 (nM1), .nRfsh (nRfsh), .nHalt (nHalt),
        .cpuAddress (cpuAddress), .romDisable (romDisable),
        .memRd (memRd), .memWr (memWr), .ioRd (ioRd), .ioWr (ioWr),
        .romSel (romSel), .ramSel (ramSel),
        .ledBarSel (ledBarSel), .miscSel (miscSel),
        .pageSel (pageSel), .panelSel (panelSel),
        .bootNop (bootNop), .cycleStart (cycleStart), .status (status)
    );

    portExecute execute (
        .pll0_2MHz (pll0_2MHz), .n_reset (n_reset),
        .cpuDataOut (cpuDataOut), .ioWr (ioWr),
        .ledBarSel (ledBarSel), .miscSel (miscSel),
        .pageSel (pageSel), .panelSel (panelSel),
        .cycleStart (cycleStart), .romSel (romSel),
        .memRd (memRd), .ioRd (ioRd),
        .barLeds (barLeds), .frontPanel (frontPanel),
        .romDisable (romDisable), .romBank (romBank),
        .ramPage (ramPage), .nWait (nWait)
    );

    busResult result (
        .pll0_2MHz (pll0_2MHz), .n_reset (n_reset),
        .cpuAddress (cpuAddress),
        .memRd (memRd), .memWr (memWr), .ioRd (ioRd),
        .romSel (romSel), .ramSel (ramSel),
        .ledBarSel (ledBarSel), .pageSel (pageSel),
        .bootNop (bootNop), .cycleStart (cycleStart), .status (status),
        .romBank (romBank), .ramPage (ramPage), .barLeds (barLeds),
        .ioByte (ioByte), .romData (romData),
        .ramDataIn (ramDataIn), .s100DataIn (s100DataIn),
        .cpuDataIn (cpuDataIn), .romAddress (romAddress),
        .ramAddress (ramAddress), .ramNcs (ramNcs),
        .ramNoe (ramNoe), .ramNwr (ramNwr),
        .s100Address (s100Address), .s100Status (s100Status)
    );

endmodule

// File: tests/clockGen.sv
// Testbench clock and reset source: 20-unit pll0_2MHz period, reset held low for 4 cycles
module clockGen (
    output logic pll0_2MHz,
    output logic n_reset
);

    initial begin
        pll0_2MHz = 1'b0;
    end

    always #10 pll0_2MHz = ~pll0_2MHz;         // half of the 20-unit period

    initial begin
        n_reset <= 1'b0;                        // held from time zero
        repeat (4) @(posedge pll0_2MHz);
        n_reset <= 1'b1;                        // released on the 4th edge
    end

endmodule

// File: tests/sbcBus_asserts.sv
// Bound bus glue checks: RAM/ROM select exclusion, I/O status sanity, WAIT after reset
`include "sbc_config.svh"

module sbcBus_asserts (
    input logic                         pll0_2MHz,
    input logic                         n_reset,
    input logic                         ramNcs,
    input logic                         romSel,
    input logic                         nWait,
    input logic [`STATUS_WIDTH-1:0]     status
);

    // ram chip select stays off inside the rom window
    romExcludesRam: assert property (@(posedge pll0_2MHz) disable iff (!n_reset)
        romSel |-> ramNcs)
        else $error("ram chip select low while rom is selected");

    // IN and OUT are never live in the same cycle
    ioDirectionUnique: assert property (@(posedge pll0_2MHz) disable iff (!n_reset)
        !(status[`ST_OUT] && status[`ST_INP]))
        else $error("status out and inp set together");

    waitIdleAfterReset: assert property (@(posedge pll0_2MHz)
        !n_reset |=> nWait)
        else $error("wait asserted in the cycle after reset");

endmodule

bind sbcBusTop sbcBus_asserts checks (
    .pll0_2MHz (pll0_2MHz),
    .n_reset   (n_reset),
    .ramNcs    (ramNcs),
    .romSel    (romSel),
    .nWait     (nWait),
    .status    (status)
);

// File: tests/sbcBusTb.sv
// Testbench for the SBC bus glue: plays the Z80 bus and checks decode, ports and latches
`include "sbc_config.svh"

module sbcBusTb;

    localparam int WAIT_LIMIT  = 20;            // clocks a bus cycle may stretch
    localparam int RESET_LIMIT = 20;

    logic                           pll0_2MHz;
    logic                           n_reset;
    logic                           nMreq;
    logic                           nIorq;
    logic                           nRd;
    logic                           nWr;
    logic                           nM1;
    logic                           nRfsh;
    logic                           nHalt;
    sbcBusPkg::cpuAddress_u         cpuAddress;
    logic [7:0]                     cpuDataOut;
    logic [7:0]                     romData;
    logic [7:0]                     ramDataIn;
    logic [7:0]                     s100DataIn;
    logic [7:0]                     ioByte;
    logic [7:0]                     cpuDataIn;
    logic                           nWait;
    logic [`ROM_ADDR_WIDTH-1:0]     romAddress;
    logic [`RAM_ADDR_WIDTH-1:0]     ramAddress;
    logic                           ramNcs;
    logic                           ramNoe;
    logic                           ramNwr;
    sbcBusPkg::cpuAddress_u         s100Address;
    logic [`STATUS_WIDTH-1:0]       s100Status;
    logic [7:0]                     barLeds;
    logic [7:0]                     frontPanel;

    // what the cpu saw at the end of the last bus cycle
    logic [7:0]                     seenData;
    logic [7:0]                     seenWaits;
    logic [`ROM_ADDR_WIDTH-1:0]     seenRomAddress;
    logic [`RAM_ADDR_WIDTH-1:0]     seenRamAddress;
    logic                           seenRamNcs;
    logic                           seenRamNoe;
    logic                           seenRamNwr;

    integer seed;
    string  testName;
    int     checkCount;
    int     errorCount;
    int     testChecks;
    int     testErrors;

    clockGen clocks (
        .pll0_2MHz (pll0_2MHz),
        .n_reset   (n_reset)
    );

    sbcBusTop UUT (.*);

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] randByte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $finish;
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    task automatic endTest();
        $display("%-10s %0d checks, %0d errors", testName,
                 checkCount - testChecks, errorCount - testErrors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkByte(input logic [7:0] expected, input logic [7:0] actual,
                             input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error %s %s: expected %02h, actual %02h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic checkBit(input logic expected, input logic actual, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error %s %s: expected %0b, actual %0b", testName, what, expected, actual);
        end
    endtask

    task automatic checkAddr(input sbcBusPkg::cpuAddress_u expected,
                             input sbcBusPkg::cpuAddress_u actual, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error %s %s: expected %04h, actual %04h",
                     testName, what, expected.mem, actual.mem);
        end
    endtask

    task automatic checkStatus(input logic [`STATUS_WIDTH-1:0] expected,
                               input logic [`STATUS_WIDTH-1:0] actual, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error %s %s: expected %07b, actual %07b",
                     testName, what, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // z80 bus cycles
    //////////////////////////////////////////////////////////////////////

    task automatic runCycle(input logic mem, input logic rd,
                            input sbcBusPkg::cpuAddress_u addr, input logic [7:0] wdata);
        int waited;
        waited = 0;
        @(posedge pll0_2MHz);
        cpuAddress <= addr;
        cpuDataOut <= wdata;
        nMreq      <= !mem;
        nIorq      <= mem;
        nRd        <= !rd;
        nWr        <= rd;
        @(posedge pll0_2MHz);                   // wait register loads here
        @(negedge pll0_2MHz);
        while (!nWait) begin                    // one pass per wait clock
            waited++;
            if (waited > WAIT_LIMIT) abortRun("bus cycle stuck, nWait never returned high");
            @(negedge pll0_2MHz);
        end
        seenWaits      = waited[7:0];
        seenData       = cpuDataIn;
        seenRomAddress = romAddress;
        seenRamAddress = ramAddress;
        seenRamNcs     = ramNcs;
        seenRamNoe     = ramNoe;
        seenRamNwr     = ramNwr;
        @(posedge pll0_2MHz);
        nMreq <= 1'b1;
        nIorq <= 1'b1;
        nRd   <= 1'b1;
        nWr   <= 1'b1;
        @(negedge pll0_2MHz);                   // registered outputs settled
    endtask

    task automatic memRead(input sbcBusPkg::cpuAddress_u addr);
        runCycle(1'b1, 1'b1, addr, 8'h00);
    endtask

    task automatic memWrite(input sbcBusPkg::cpuAddress_u addr, input logic [7:0] data);
        runCycle(1'b1, 1'b0, addr, data);
    endtask

    task automatic ioRead(input sbcBusPkg::cpuAddress_u addr);
        runCycle(1'b0, 1'b1, addr, 8'h00);
    endtask

    task automatic ioWrite(input sbcBusPkg::cpuAddress_u addr, input logic [7:0] data);
        runCycle(1'b0, 1'b0, addr, data);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic bootNopTest();
        logic [7:0] ramVal;
        logic [7:0] romVal;
        startTest("bootNop");
        ramVal = randByte() | 8'h80;            // never 00, so a nop is visible
        romVal = randByte();
        @(posedge pll0_2MHz);
        ramDataIn <= ramVal;
        romData   <= romVal;
        memRead(16'h0000);
        checkByte(8'h00, seenData, "nop at 0000");
        memRead(16'h0001);
        checkByte(8'h00, seenData, "nop at 0001");
        memRead(16'hF000);
        checkByte(romVal, seenData, "rom at F000");
        memRead(16'h0000);                      // feed is over
        checkByte(ramVal, seenData, "ram at 0000");
        endTest();
    endtask

    task automatic portTest();
        logic [7:0] ledVal;
        logic [7:0] panelVal;
        logic [7:0] switchVal;
        startTest("ports");
        ledVal    = randByte();
        panelVal  = randByte();
        switchVal = randByte();
        ioWrite({ledVal, `PORT_LEDBAR}, ledVal);
        ioWrite({panelVal, `PORT_PANEL}, panelVal);
        checkByte(ledVal, barLeds, "barLeds");
        checkByte(panelVal, frontPanel, "frontPanel");
        ioRead({8'h00, `PORT_LEDBAR});
        checkByte(ledVal, seenData, "port 06 read");
        @(posedge pll0_2MHz);
        ioByte <= switchVal;
        ioRead({8'h00, `PORT_PAGE});
        checkByte(switchVal, seenData, "port 36 read");
        endTest();
    endtask

    task automatic romBankTest();
        logic [7:0] ramVal;
        startTest("romBank");
        ramVal = randByte();
        ioWrite({8'h05, `PORT_MISC}, 8'h05);    // bank 3, rom on
        memRead(16'hF123);
        checkByte(8'h03, {6'b000000, seenRomAddress[13:12]}, "rom bank bits");
        checkByte(8'h23, seenRomAddress[7:0], "rom low address");
        @(posedge pll0_2MHz);
        ramDataIn <= ramVal;
        ioWrite({8'h02, `PORT_MISC}, 8'h02);    // rom off
        memRead(16'hF123);
        checkBit(1'b0, seenRamNcs, "ramNcs at F123");
        checkByte(ramVal, seenData, "ram at F123");
        ioWrite({8'h00, `PORT_MISC}, 8'h00);
        endTest();
    endtask

    task automatic ramPageTest();
        startTest("ramPage");
        ioWrite({8'h01, `PORT_PAGE}, 8'h01);
        memRead(16'h1234);
        checkBit(1'b1, seenRamAddress[16], "A16 at 1234");
        checkBit(1'b0, seenRamNoe, "ramNoe on read");
        memRead(16'h9234);                      // upper half is common
        checkBit(1'b0, seenRamAddress[16], "A16 at 9234");
        memWrite(16'h1234, randByte());
        checkBit(1'b0, seenRamNwr, "ramNwr on write");
        checkBit(1'b1, seenRamNoe, "ramNoe on write");
        ioWrite({8'h00, `PORT_PAGE}, 8'h00);
        endTest();
    endtask

    task automatic waitStatusTest();
        logic [`STATUS_WIDTH-1:0] outStatus;
        startTest("waitStatus");
        outStatus           = '0;
        outStatus[`ST_OUT]  = 1'b1;             // nWo low, inp and memr clear
        memRead(16'hF000);
        checkByte(8'd1, seenWaits, "rom read waits");
        ioWrite({8'hAB, `PORT_MISC}, 8'h00);
        checkByte(8'd2, seenWaits, "io write waits");
        checkAddr(16'h0007, s100Address, "s100Address");
        checkStatus(outStatus, s100Status, "s100Status");
        endTest();
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int waited;
        seed       = 32'heb01;
        checkCount = 0;
        errorCount = 0;
        waited     = 0;
        nMreq      <= 1'b1;                     // bus idle
        nIorq      <= 1'b1;
        nRd        <= 1'b1;
        nWr        <= 1'b1;
        nM1        <= 1'b1;
        nRfsh      <= 1'b1;
        nHalt      <= 1'b1;
        cpuAddress <= 16'h0000;
        cpuDataOut <= 8'h00;
        romData    <= 8'h00;
        ramDataIn  <= 8'h00;
        s100DataIn <= 8'h00;
        ioByte     <= 8'h00;
        @(negedge pll0_2MHz);
        while (!n_reset) begin
            waited++;
            if (waited > RESET_LIMIT) abortRun("reset was never released");
            @(negedge pll0_2MHz);
        end
        bootNopTest();
        portTest();
        romBankTest();
        ramPageTest();
        waitStatusTest();
        $display("5 tests, %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+rtl
rtl/sbcBusPkg.sv
rtl/busDecode.sv
rtl/portExecute.sv
rtl/busResult.sv
rtl/sbcBusTop.sv
tests/clockGen.sv
tests/sbcBus_asserts.sv
tests/sbcBusTb.sv

// File: run.sh
#!/bin/bash
# build the testbench with Verilator, run it, then scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timing -f tb.f --top-module sbcBusTb -Mdir obj_dir
./obj_dir/VsbcBusTb | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
